// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// width of a register and of the pc
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// fetch restarts here while rst is high
`define RV_RESET_PC 0

// one 32-bit instruction per cycle, no compressed forms
`define RV_PC_STEP 4

`endif

// File: rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // register contents and pc values
  typedef logic [`RV_XLEN-1:0] word_t;

  // raw instruction bits, always 32 in RV32
  typedef logic [31:0] insn_t;

  // index into the register file
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // major opcode field insn[6:0]
  // only the formats this core executes are listed
  typedef enum logic [6:0] {
    OPC_REG_IMM = 7'b0010011,
    OPC_REG_REG = 7'b0110011,
    OPC_LUI     = 7'b0110111
  } opcode_e;

  // per-slot status carried alongside every instruction
  // checked at writeback to confirm pipeline timing
  typedef enum logic [2:0] {
    // must not show up once reset has been seen
    CYCLE_INVALID  = 3'd0,
    // bubble created by reset
    CYCLE_RESET    = 3'd1,
    // real instruction in the slot
    CYCLE_NO_STALL = 3'd2
  } cycle_status_e;

endpackage

// File: rv_regfile.sv
`include "rv_params.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::word_t    rd_data_i,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  // one read port
  // x0 is hardwired, a same-cycle write wins over the stored word
  function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we_i && (idx == rd_i)) begin
      return rd_data_i;
    end
    return regs[idx];
  endfunction

  // we_i already excludes x0, so no index check here
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // reads follow the stored words and the write port, not just the indices
  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule

// File: rv_fetch_decode.sv
`include "rv_params.svh"

module rv_fetch_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::insn_t         insn_i,
  input  logic                  wb_we_i,
  input  rv_pkg::reg_idx_t      wb_rd_i,
  input  rv_pkg::word_t         wb_data_i,
  output rv_pkg::word_t         pc_o,
  output rv_pkg::word_t         d_pc_o,
  output rv_pkg::insn_t         d_insn_o,
  output rv_pkg::cycle_status_e d_status_o,
  output rv_pkg::word_t         d_rs1_data_o,
  output rv_pkg::word_t         d_rs2_data_o
);

  // fetch pc, also the address sent to instruction memory
  rv_pkg::word_t pc_q;

  // decode stage register
  rv_pkg::word_t         d_pc_q;
  rv_pkg::insn_t         d_insn_q;
  rv_pkg::cycle_status_e d_status_q;

  // source register fields of the instruction in decode
  rv_pkg::reg_idx_t d_rs1;
  rv_pkg::reg_idx_t d_rs2;

  // no branches, so the pc just steps every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_RESET_PC;
    end else begin
      pc_q <= pc_q + `RV_PC_STEP;
    end
  end

  // instruction arrives in the same cycle as its pc
  // reset leaves a bubble tagged as such
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc_q     <= '0;
      d_insn_q   <= '0;
      d_status_q <= rv_pkg::CYCLE_RESET;
    end else begin
      d_pc_q     <= pc_q;
      d_insn_q   <= insn_i;
      d_status_q <= rv_pkg::CYCLE_NO_STALL;
    end
  end

  // rs1 and rs2 sit at the same place in every format
  assign d_rs1 = d_insn_q[19:15];
  assign d_rs2 = d_insn_q[24:20];

  // write port comes straight from writeback
  // write-through covers a producer three slots ahead
  rv_regfile rf_inst (
    .clk        (clk),
    .rst        (rst),
    .we_i       (wb_we_i),
    .rd_i       (wb_rd_i),
    .rd_data_i  (wb_data_i),
    .rs1_i      (d_rs1),
    .rs2_i      (d_rs2),
    .rs1_data_o (d_rs1_data_o),
    .rs2_data_o (d_rs2_data_o)
  );

  assign pc_o       = pc_q;
  assign d_pc_o     = d_pc_q;
  assign d_insn_o   = d_insn_q;
  assign d_status_o = d_status_q;

endmodule

// File: rv_execute.sv
`include "rv_params.svh"

module rv_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         d_pc_i,
  input  rv_pkg::insn_t         d_insn_i,
  input  rv_pkg::cycle_status_e d_status_i,
  input  rv_pkg::word_t         d_rs1_data_i,
  input  rv_pkg::word_t         d_rs2_data_i,
  input  logic                  m_we_i,
  input  rv_pkg::reg_idx_t      m_rd_i,
  input  rv_pkg::word_t         m_result_i,
  input  logic                  w_we_i,
  input  rv_pkg::reg_idx_t      w_rd_i,
  input  rv_pkg::word_t         w_result_i,
  output rv_pkg::word_t         e_pc_o,
  output rv_pkg::insn_t         e_insn_o,
  output rv_pkg::cycle_status_e e_status_o,
  output rv_pkg::word_t         e_result_o
);

  // execute stage register, control part
  rv_pkg::word_t         e_pc_q;
  rv_pkg::insn_t         e_insn_q;
  rv_pkg::cycle_status_e e_status_q;
  // operand values read in decode
  rv_pkg::word_t         e_rs1_data_q;
  rv_pkg::word_t         e_rs2_data_q;

  rv_pkg::opcode_e e_opcode;
  logic [2:0]      e_funct3;
  logic [6:0]      e_funct7;
  rv_pkg::word_t   e_imm_i;
  rv_pkg::word_t   e_op1;
  rv_pkg::word_t   e_op2;

  always_ff @(posedge clk) begin
    if (rst) begin
      e_pc_q     <= '0;
      e_insn_q   <= '0;
      e_status_q <= rv_pkg::CYCLE_RESET;
    end else begin
      e_pc_q     <= d_pc_i;
      e_insn_q   <= d_insn_i;
      e_status_q <= d_status_i;
    end
  end

  always_ff @(posedge clk) begin
    e_rs1_data_q <= d_rs1_data_i;
    e_rs2_data_q <= d_rs2_data_i;
  end

  assign e_opcode = rv_pkg::opcode_e'(e_insn_q[6:0]);
  assign e_funct3 = e_insn_q[14:12];
  assign e_funct7 = e_insn_q[31:25];
  // I-type immediate, sign extended
  assign e_imm_i  = {{(`RV_XLEN-12){e_insn_q[31]}}, e_insn_q[31:20]};

  // bypass: memory stage is younger, so it beats writeback
  // write flags already drop x0 and non-writing instructions
  always_comb begin
    if (m_we_i && (m_rd_i == e_insn_q[19:15])) begin
      e_op1 = m_result_i;
    end else if (w_we_i && (w_rd_i == e_insn_q[19:15])) begin
      e_op1 = w_result_i;
    end else begin
      e_op1 = e_rs1_data_q;
    end
    if (m_we_i && (m_rd_i == e_insn_q[24:20])) begin
      e_op2 = m_result_i;
    end else if (w_we_i && (w_rd_i == e_insn_q[24:20])) begin
      e_op2 = w_result_i;
    end else begin
      e_op2 = e_rs2_data_q;
    end
  end

  // alu, anything not implemented yields zero
  always_comb begin
    e_result_o = '0;
    case (e_opcode)
      rv_pkg::OPC_LUI: e_result_o = {e_insn_q[31:12], 12'b0};
      rv_pkg::OPC_REG_IMM: begin
        // addi only
        if (e_funct3 == 3'b000) begin
          e_result_o = e_op1 + e_imm_i;
        end
      end
      rv_pkg::OPC_REG_REG: begin
        if ((e_funct3 == 3'b000) && (e_funct7 == 7'b0000000)) begin
          e_result_o = e_op1 + e_op2;
        end else if ((e_funct3 == 3'b000) && (e_funct7 == 7'b0100000)) begin
          e_result_o = e_op1 - e_op2;
        end
      end
      default: e_result_o = '0;
    endcase
  end

  assign e_pc_o     = e_pc_q;
  assign e_insn_o   = e_insn_q;
  assign e_status_o = e_status_q;

endmodule

// File: rv_writeback.sv
module rv_writeback (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         e_pc_i,
  input  rv_pkg::insn_t         e_insn_i,
  input  rv_pkg::cycle_status_e e_status_i,
  input  rv_pkg::word_t         e_result_i,
  output logic                  m_we_o,
  output rv_pkg::reg_idx_t      m_rd_o,
  output rv_pkg::word_t         m_result_o,
  output logic                  w_we_o,
  output rv_pkg::reg_idx_t      w_rd_o,
  output rv_pkg::word_t         w_result_o,
  output rv_pkg::word_t         trace_pc_o,
  output rv_pkg::insn_t         trace_insn_o,
  output rv_pkg::cycle_status_e trace_status_o
);

  // memory stage register
  rv_pkg::word_t         m_pc_q;
  rv_pkg::insn_t         m_insn_q;
  rv_pkg::cycle_status_e m_status_q;
  rv_pkg::word_t         m_result_q;

  // writeback stage register
  rv_pkg::word_t         w_pc_q;
  rv_pkg::insn_t         w_insn_q;
  rv_pkg::cycle_status_e w_status_q;
  rv_pkg::word_t         w_result_q;

  // true when the instruction writes a real register
  // rd of x0 counts as no write
  function automatic logic writes_rd(input rv_pkg::insn_t insn);
    logic hit;
    hit = 1'b0;
    case (rv_pkg::opcode_e'(insn[6:0]))
      rv_pkg::OPC_LUI:     hit = 1'b1;
      rv_pkg::OPC_REG_IMM: hit = (insn[14:12] == 3'b000);
      rv_pkg::OPC_REG_REG: begin
        hit = (insn[14:12] == 3'b000) &&
              ((insn[31:25] == 7'b0000000) || (insn[31:25] == 7'b0100000));
      end
      default: hit = 1'b0;
    endcase
    return hit && (insn[11:7] != 5'd0);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc_q     <= '0;
      m_insn_q   <= '0;
      m_status_q <= rv_pkg::CYCLE_RESET;
      w_pc_q     <= '0;
      w_insn_q   <= '0;
      w_status_q <= rv_pkg::CYCLE_RESET;
    end else begin
      m_pc_q     <= e_pc_i;
      m_insn_q   <= e_insn_i;
      m_status_q <= e_status_i;
      w_pc_q     <= m_pc_q;
      w_insn_q   <= m_insn_q;
      w_status_q <= m_status_q;
    end
  end

  // results are payload, they follow the instruction
  always_ff @(posedge clk) begin
    m_result_q <= e_result_i;
    w_result_q <= m_result_q;
  end

  // no loads here, so the memory result is final and can be bypassed
  assign m_we_o     = writes_rd(m_insn_q);
  assign m_rd_o     = m_insn_q[11:7];
  assign m_result_o = m_result_q;

  assign w_we_o     = writes_rd(w_insn_q);
  assign w_rd_o     = w_insn_q[11:7];
  assign w_result_o = w_result_q;

  assign trace_pc_o     = w_pc_q;
  assign trace_insn_o   = w_insn_q;
  assign trace_status_o = w_status_q;

endmodule

// File: rv_pipe_top.sv
module rv_pipe_top (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::insn_t         insn_i,
  output rv_pkg::word_t         pc_o,
  output rv_pkg::word_t         trace_pc_o,
  output rv_pkg::insn_t         trace_insn_o,
  output rv_pkg::cycle_status_e trace_status_o,
  output logic                  wb_we_o,
  output rv_pkg::reg_idx_t      wb_rd_o,
  output rv_pkg::word_t         wb_data_o
);

  // decode to execute
  rv_pkg::word_t         d_pc;
  rv_pkg::insn_t         d_insn;
  rv_pkg::cycle_status_e d_status;
  rv_pkg::word_t         d_rs1_data;
  rv_pkg::word_t         d_rs2_data;

  // execute to memory
  rv_pkg::word_t         e_pc;
  rv_pkg::insn_t         e_insn;
  rv_pkg::cycle_status_e e_status;
  rv_pkg::word_t         e_result;

  // bypass from memory stage
  logic             m_we;
  rv_pkg::reg_idx_t m_rd;
  rv_pkg::word_t    m_result;

  rv_fetch_decode fd_inst (
    .clk, .rst, .insn_i, .pc_o,
    .wb_we_i (wb_we_o), .wb_rd_i (wb_rd_o), .wb_data_i (wb_data_o),
    .d_pc_o (d_pc), .d_insn_o (d_insn), .d_status_o (d_status),
    .d_rs1_data_o (d_rs1_data), .d_rs2_data_o (d_rs2_data)
  );

  rv_execute ex_inst (
    .clk, .rst,
    .d_pc_i (d_pc), .d_insn_i (d_insn), .d_status_i (d_status),
    .d_rs1_data_i (d_rs1_data), .d_rs2_data_i (d_rs2_data),
    .m_we_i (m_we), .m_rd_i (m_rd), .m_result_i (m_result),
    .w_we_i (wb_we_o), .w_rd_i (wb_rd_o), .w_result_i (wb_data_o),
    .e_pc_o (e_pc), .e_insn_o (e_insn), .e_status_o (e_status), .e_result_o (e_result)
  );

  // writeback triple doubles as the register write port
  rv_writeback wb_inst (
    .clk, .rst,
    .e_pc_i (e_pc), .e_insn_i (e_insn), .e_status_i (e_status), .e_result_i (e_result),
    .m_we_o (m_we), .m_rd_o (m_rd), .m_result_o (m_result),
    .w_we_o (wb_we_o), .w_rd_o (wb_rd_o), .w_result_o (wb_data_o),
    .trace_pc_o, .trace_insn_o, .trace_status_o
  );

endmodule

// File: rv_pipe_assertions.sv
`include "rv_params.svh"

module rv_pipe_assertions (
  input logic                  clk,
  input logic                  rst,
  input rv_pkg::word_t         pc_i,
  input rv_pkg::cycle_status_e trace_status_i,
  input logic                  wb_we_i,
  input rv_pkg::reg_idx_t      wb_rd_i
);

  // read by the testbench
  int fail_count = 0;

  // every writeback slot is either a bubble or an instruction
  status_known: assert property (@(posedge clk) disable iff (rst)
    trace_status_i != rv_pkg::CYCLE_INVALID)
    else begin
      fail_count++;
      $error("trace status reads CYCLE_INVALID");
    end

  // write flag already excludes x0
  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wb_we_i |-> (wb_rd_i != '0))
    else begin
      fail_count++;
      $error("register write enabled with rd of x0");
    end

  // no branches and no stalls, so fetch always steps
  pc_steps: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (pc_i == $past(pc_i) + `RV_PC_STEP))
    else begin
      fail_count++;
      $error("pc did not advance by one instruction");
    end

endmodule

bind rv_pipe_top rv_pipe_assertions rv_pipe_assertions_inst (
  .clk            (clk),
  .rst            (rst),
  .pc_i           (pc_o),
  .trace_status_i (trace_status_o),
  .wb_we_i        (wb_we_o),
  .wb_rd_i        (wb_rd_o)
);

// File: tb_rv_pipe.sv
`include "rv_params.svh"

module tb_rv_pipe;

  // stimulus file, relative to the project root
  localparam string CASES_FILE = "rv_pipe_cases.txt";
  localparam int MAX_CASES = 64;
  // four columns per line in the cases file
  localparam int COLS = 4;
  localparam int TIMEOUT_CYCLES = 20;
  // bubbles seen at writeback after the first edge with rst low
  localparam int RESET_BUBBLES = 3;

  logic                  clk;
  logic                  rst;
  rv_pkg::insn_t         insn_i;
  rv_pkg::word_t         pc_o;
  rv_pkg::word_t         trace_pc_o;
  rv_pkg::insn_t         trace_insn_o;
  rv_pkg::cycle_status_e trace_status_o;
  logic                  wb_we_o;
  rv_pkg::reg_idx_t      wb_rd_o;
  rv_pkg::word_t         wb_data_o;

  // flat image of the cases file
  logic [31:0] case_words [COLS*MAX_CASES];
  int          num_cases;

  rv_pipe_top rv_pipe_top_inst (
    .clk,
    .rst,
    .insn_i,
    .pc_o,
    .trace_pc_o,
    .trace_insn_o,
    .trace_status_o,
    .wb_we_o,
    .wb_rd_o,
    .wb_data_o
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t got,
                            input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_idx(input string name, input rv_pkg::reg_idx_t got,
                           input rv_pkg::reg_idx_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_status(input string name, input rv_pkg::cycle_status_e got,
                              input rv_pkg::cycle_status_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s (%0d), expected %s", $time, name,
               got.name(), got, exp.name());
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // next writeback slot holding a real instruction
  // every bubble on the way must keep the write port quiet
  task automatic wait_trace_valid(output int bubbles);
    int waited;
    waited = 0;
    bubbles = 0;
    @(negedge clk);
    while (trace_status_o !== rv_pkg::CYCLE_NO_STALL) begin
      check_status("trace_status_o", trace_status_o, rv_pkg::CYCLE_RESET);
      check_bit("wb_we_o", wb_we_o, 1'b0);
      bubbles++;
      waited++;
      if (waited >= TIMEOUT_CYCLES) begin
        $display("timeout: no valid instruction reached writeback in %0d cycles",
                 TIMEOUT_CYCLES);
        end_with_failure();
      end
      @(negedge clk);
    end
  endtask

  // line n goes out while pc_o is 4n, line 0 is already on insn_i
  // started at the edge that fetches line 0 and moves pc_o to 4
  task automatic feed_insns();
    for (int n = 1; n <= num_cases; n++) begin
      if (n < num_cases) begin
        insn_i <= case_words[COLS*n];
      end else begin
        insn_i <= '0;
      end
      @(negedge clk);
      check_word("pc_o", pc_o, `RV_PC_STEP * n);
      @(posedge clk);
    end
  endtask

  task automatic check_trace();
    int               bubbles;
    int               exp_bubbles;
    logic             exp_we;
    rv_pkg::reg_idx_t exp_rd;
    rv_pkg::word_t    exp_data;
    for (int n = 0; n < num_cases; n++) begin
      exp_we      = case_words[COLS*n+1][0];
      exp_rd      = case_words[COLS*n+2][4:0];
      exp_data    = case_words[COLS*n+3];
      exp_bubbles = (n == 0) ? RESET_BUBBLES : 0;
      wait_trace_valid(bubbles);
      if (bubbles != exp_bubbles) begin
        $display("mismatch at %0t: bubbles before trace %0d is %0d, expected %0d",
                 $time, n, bubbles, exp_bubbles);
        end_with_failure();
      end
      check_word("trace_pc_o", trace_pc_o, `RV_PC_STEP * n);
      check_word("trace_insn_o", trace_insn_o, case_words[COLS*n]);
      check_bit("wb_we_o", wb_we_o, exp_we);
      // rd only matters when the write goes through
      if (exp_we) begin
        check_idx("wb_rd_o", wb_rd_o, exp_rd);
      end
      check_word("wb_data_o", wb_data_o, exp_data);
    end
  endtask

  // the bound checker counts its failed assertions
  always @(negedge clk) begin
    if (rv_pipe_top_inst.rv_pipe_assertions_inst.fail_count != 0) begin
      $display("an assertion in the bound checker failed");
      end_with_failure();
    end
  end

  initial begin
    rst = 1'b1;
    insn_i = '0;
    $readmemh(CASES_FILE, case_words);
    num_cases = 0;
    while ((num_cases < MAX_CASES) && !$isunknown(case_words[COLS*num_cases])) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("no instructions could be read from %s", CASES_FILE);
      end_with_failure();
    end
    insn_i = case_words[0];
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // first edge that sees rst low fetches line 0
    @(posedge clk);
    fork
      feed_insns();
      check_trace();
    join
    if (rv_pipe_top_inst.rv_pipe_assertions_inst.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("an assertion in the bound checker failed");
      end_with_failure();
    end
  end

endmodule

// File: rv_pipe_cases.txt
// columns: instruction, expected wb_we_o, expected wb_rd_o, expected wb_data_o (hex)
// line n is fetched at pc 4n, registers start at zero
123450B7 1 01 12345000 // lui  x1, 0x12345
FFF08113 1 02 12344FFF // addi x2, x1, -1       x1 at distance 1
002081B3 1 03 24689FFF // add  x3, x1, x2       distances 2 and 1
40100233 1 04 EDCBB000 // sub  x4, x0, x1       x1 through regfile write-through
7FF00293 1 05 000007FF // addi x5, x0, 2047
80000337 1 06 80000000 // lui  x6, 0x80000
FFF30313 1 06 7FFFFFFF // addi x6, x6, -1
006303B3 1 07 FFFFFFFE // add  x7, x6, x6       signed overflow wraps
40728433 1 08 00000801 // sub  x8, x5, x7       unsigned wrap
00508013 0 00 12345005 // addi x0, x1, 5        write to x0 dropped
00102023 0 00 00000000 // sw   x1, 0(x0)        unsupported opcode
ABCDE037 0 00 ABCDE000 // lui  x0, 0xabcde      write to x0 dropped
000004B3 1 09 00000000 // add  x9, x0, x0       x0 still zero
12300513 1 0A 00000123 // addi x10, x0, 0x123
022085B3 0 00 00000000 // mul  x11, x1, x2      unsupported funct7
40950633 1 0C 00000123 // sub  x12, x10, x9
004606B3 1 0D EDCBB123 // add  x13, x12, x4
80068713 1 0E EDCBA923 // addi x14, x13, -2048
403707B3 1 0F C9630924 // sub  x15, x14, x3
00108093 1 01 12345001 // addi x1, x1, 1
001080B3 1 01 2468A002 // add  x1, x1, x1       chain on x1
40208133 1 02 12345003 // sub  x2, x1, x2

// File: list.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_fetch_decode.sv
rv_execute.sv
rv_writeback.sv
rv_pipe_top.sv
rv_pipe_assertions.sv
tb_rv_pipe.sv

// File: Bender.yml
package:
  name: rv_pipe

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_regfile.sv
      - rv_fetch_decode.sv
      - rv_execute.sv
      - rv_writeback.sv
      - rv_pipe_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_pipe_assertions.sv
      - tb_rv_pipe.sv
